// File: hw/ex_pkg.sv
/*
 * Shared RV32 execute stage definitions:
 * widths, exception cause codes, the operator enum and the
 * issue, prediction, resolution, exception and write-back records
 */
`default_nettype none

package ex_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    localparam int unsigned XLEN          = 32;
    localparam int unsigned TRANS_ID_BITS = 3;
    localparam int unsigned CSR_ADDR_BITS = 12;

    // Exception cause codes
    localparam logic [XLEN-1:0] INSTR_ADDR_MISALIGNED = 32'd0;

    // ------------------------------------------------------------
    // Operators
    // ------------------------------------------------------------
    typedef enum logic [4:0] {
        // ALU
        ADD, SUB, SLL, SRL, SRA, SLTS, SLTU, XORL, ORL, ANDL,
        // Branch compares and indirect jump
        EQ, NE, LTS, GES, LTU, GEU, JALR,
        // CSR access
        CSR_RW,
        // Multiplier
        MUL, MULH, MULHU
    } fu_op_e;

    // ------------------------------------------------------------
    // Records
    // ------------------------------------------------------------
    typedef struct packed {
        fu_op_e                   operator;
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          operand_b;
        logic [XLEN-1:0]          imm;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    typedef struct packed {
        logic            predict_taken;
        logic [XLEN-1:0] predict_address;
    } branchpredict_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target_address;
        logic            is_mispredict;
        logic            is_taken;
    } bp_resolve_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] cause;
        logic [XLEN-1:0] tval;   // faulting address
    } exception_t;

    typedef struct packed {
        logic                     valid;
        logic [XLEN-1:0]          result;
        logic [TRANS_ID_BITS-1:0] trans_id;
        exception_t               exception;
    } flu_out_t;

endpackage

`default_nettype wire

// File: hw/alu.sv
/*
 * Combinational ALU
 * Add, subtract, shifts, set-less-than and logic operations,
 * plus the branch comparison used by the branch unit
 */
`timescale 1ns/1ps
`default_nettype none

module alu import ex_pkg::*; (
    input  fu_data_t        fu_data_i,
    output logic [XLEN-1:0] result_o,
    output logic            branch_res_o
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;
    logic            less_signed;
    logic            less_unsigned;

    assign op_a  = fu_data_i.operand_a;
    assign op_b  = fu_data_i.operand_b;
    assign shamt = op_b[4:0];

    // Shared comparators for SLT and the branches
    assign less_signed   = $signed(op_a) < $signed(op_b);
    assign less_unsigned = op_a < op_b;

    // ------------------------------------------------------------
    // Result
    // ------------------------------------------------------------
    always_comb begin
        result_o = '0;
        case (fu_data_i.operator)
            ADD:  result_o = op_a + op_b;
            SUB:  result_o = op_a - op_b;
            SLL:  result_o = op_a << shamt;
            SRL:  result_o = op_a >> shamt;
            SRA:  result_o = $unsigned($signed(op_a) >>> shamt);
            SLTS: result_o = {{(XLEN-1){1'b0}}, less_signed};
            SLTU: result_o = {{(XLEN-1){1'b0}}, less_unsigned};
            XORL: result_o = op_a ^ op_b;
            ORL:  result_o = op_a | op_b;
            ANDL: result_o = op_a & op_b;
            default: result_o = '0;
        endcase
    end

    // ------------------------------------------------------------
    // Branch comparison
    // ------------------------------------------------------------
    always_comb begin
        branch_res_o = 1'b0;
        case (fu_data_i.operator)
            EQ:   branch_res_o = (op_a == op_b);
            NE:   branch_res_o = (op_a != op_b);
            LTS:  branch_res_o = less_signed;
            GES:  branch_res_o = !less_signed;
            LTU:  branch_res_o = less_unsigned;
            GEU:  branch_res_o = !less_unsigned;
            // Indirect jumps are always taken
            JALR: branch_res_o = 1'b1;
            default: branch_res_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/branch_unit.sv
/*
 * Branch unit
 * Jump and branch target, link address, resolution against the
 * prediction and misaligned-target exception
 */
`timescale 1ns/1ps
`default_nettype none

module branch_unit import ex_pkg::*; (
    input  fu_data_t        fu_data_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic            branch_valid_i,
    input  logic            branch_comp_res_i,
    input  branchpredict_t  branch_predict_i,
    output logic [XLEN-1:0] link_addr_o,
    output bp_resolve_t     resolved_branch_o,
    output logic            resolve_branch_o,
    output exception_t      branch_exception_o
);

    logic [XLEN-1:0] target;
    logic [XLEN-1:0] jalr_sum;
    logic            taken;
    logic            mispredict;

    // JALR is register relative and clears bit 0, all else is pc relative
    assign jalr_sum = fu_data_i.operand_a + fu_data_i.imm;
    assign target   = (fu_data_i.operator == JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
                                                   : pc_i + fu_data_i.imm;

    assign taken = branch_comp_res_i;

    // Wrong direction, or right direction but wrong address
    assign mispredict = (branch_predict_i.predict_taken != taken)
                      || (taken && (branch_predict_i.predict_address != target));

    // ------------------------------------------------------------
    // Outputs, all qualified by the strobe
    // ------------------------------------------------------------
    always_comb begin
        link_addr_o        = '0;
        resolved_branch_o  = '0;
        branch_exception_o = '0;

        if (branch_valid_i) begin
            // Fixed 4-byte instructions
            link_addr_o = pc_i + 32'd4;

            resolved_branch_o.valid          = 1'b1;
            resolved_branch_o.pc             = pc_i;
            resolved_branch_o.target_address = target;
            resolved_branch_o.is_taken       = taken;
            resolved_branch_o.is_mispredict  = mispredict;

            if (taken && target[1]) begin
                branch_exception_o.valid = 1'b1;
                branch_exception_o.cause = INSTR_ADDR_MISALIGNED;
                branch_exception_o.tval  = target;
            end
        end
    end

    assign resolve_branch_o = branch_valid_i;

    // Issuer may only strobe the branch unit with a branch operator
    always_comb begin
        if (resolve_branch_o) begin
            assert (fu_data_i.operator inside {EQ, NE, LTS, GES, LTU, GEU, JALR})
                else $error("branch_unit: resolve without a branch operator");
        end
    end

endmodule

`default_nettype wire

// File: hw/csr_buffer.sv
/*
 * One-entry CSR buffer
 * Holds the CSR address until commit and blocks issue while full
 */
`timescale 1ns/1ps
`default_nettype none

module csr_buffer import ex_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  fu_data_t                 fu_data_i,
    input  logic                     csr_valid_i,
    input  logic                     csr_commit_i,
    output logic                     csr_ready_o,
    output logic [XLEN-1:0]          csr_result_o,
    output logic [CSR_ADDR_BITS-1:0] csr_addr_o
);

    logic                     full_q;
    logic [CSR_ADDR_BITS-1:0] addr_q;

    // Full flag, emptied by commit or flush
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
        end else if (flush_i || csr_commit_i) begin
            full_q <= 1'b0;
        end else if (csr_valid_i) begin
            full_q <= 1'b1;
        end
    end

    // Address is taken from the low bits of operand_b
    always_ff @(posedge clk_i) begin
        if (csr_valid_i) begin
            addr_q <= fu_data_i.operand_b[CSR_ADDR_BITS-1:0];
        end
    end

    assign csr_ready_o  = !full_q;
    assign csr_result_o = fu_data_i.operand_a;
    assign csr_addr_o   = addr_q;

    // Commit only ever retires a buffered access
    commit_needs_entry: assert property (
        @(posedge clk_i) disable iff (!rst_ni) csr_commit_i |-> full_q
    ) else $error("csr_buffer: commit while empty");

    // Issuer honours ready
    no_issue_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_ni) csr_valid_i |-> !full_q
    ) else $error("csr_buffer: csr_valid_i while full");

endmodule

`default_nettype wire

// File: hw/mult.sv
/*
 * Pipelined multiplier, one cycle of latency
 * Low, signed high and unsigned high product with trans ID tracking
 */
`timescale 1ns/1ps
`default_nettype none

module mult import ex_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     mult_valid_i,
    input  fu_data_t                 fu_data_i,
    output logic [XLEN-1:0]          result_o,
    output logic                     mult_valid_o,
    output logic [TRANS_ID_BITS-1:0] mult_trans_id_o
);

    logic signed [2*XLEN-1:0] prod_signed;
    logic [2*XLEN-1:0]        prod_unsigned;
    logic [XLEN-1:0]          result_d;
    logic [XLEN-1:0]          result_q;
    logic [TRANS_ID_BITS-1:0] trans_id_q;
    logic                     valid_q;

    assign prod_signed   = $signed(fu_data_i.operand_a) * $signed(fu_data_i.operand_b);
    assign prod_unsigned = fu_data_i.operand_a * fu_data_i.operand_b;

    // Product half select
    always_comb begin
        case (fu_data_i.operator)
            MULH:    result_d = prod_signed[2*XLEN-1:XLEN];
            MULHU:   result_d = prod_unsigned[2*XLEN-1:XLEN];
            default: result_d = prod_unsigned[XLEN-1:0];
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mult_valid_i && !flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        result_q   <= result_d;
        trans_id_q <= fu_data_i.trans_id;
    end

    // A flush also kills the result returning this cycle
    assign mult_valid_o    = valid_q && !flush_i;
    assign result_o        = result_q;
    assign mult_trans_id_o = trans_id_q;

endmodule

`default_nettype wire

// File: hw/ex_stage.sv
/*
 * Fixed-latency execute stage
 * Input silencing, ALU, branch unit, CSR buffer and multiplier,
 * priority result mux and issue ready
 */
`timescale 1ns/1ps
`default_nettype none

module ex_stage import ex_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  fu_data_t                 fu_data_i,
    input  logic [XLEN-1:0]          pc_i,
    input  logic                     alu_valid_i,
    input  logic                     branch_valid_i,
    input  logic                     csr_valid_i,
    input  logic                     mult_valid_i,
    input  branchpredict_t           branch_predict_i,
    input  logic                     csr_commit_i,
    output flu_out_t                 flu_o,
    output logic                     flu_ready_o,
    output bp_resolve_t              resolved_branch_o,
    output logic                     resolve_branch_o,
    output logic [CSR_ADDR_BITS-1:0] csr_addr_o
);

    fu_data_t                 alu_data;
    fu_data_t                 mult_data;
    logic [XLEN-1:0]          alu_result;
    logic [XLEN-1:0]          csr_result;
    logic [XLEN-1:0]          mult_result;
    logic [XLEN-1:0]          link_addr;
    logic                     alu_branch_res;
    logic                     csr_ready;
    logic                     mult_valid;
    logic [TRANS_ID_BITS-1:0] mult_trans_id;
    exception_t               branch_exception;

    // ------------------------------------------------------------
    // Input silencing
    // ------------------------------------------------------------
    // ALU also does the compare for branches
    assign alu_data  = (alu_valid_i || branch_valid_i) ? fu_data_i : '0;
    assign mult_data = mult_valid_i ? fu_data_i : '0;

    // ------------------------------------------------------------
    // Units
    // ------------------------------------------------------------
    alu alu_i (
        .fu_data_i    (alu_data),
        .result_o     (alu_result),
        .branch_res_o (alu_branch_res)
    );

    branch_unit branch_unit_i (
        .fu_data_i          (fu_data_i),
        .pc_i               (pc_i),
        .branch_valid_i     (branch_valid_i),
        .branch_comp_res_i  (alu_branch_res),
        .branch_predict_i   (branch_predict_i),
        .link_addr_o        (link_addr),
        .resolved_branch_o  (resolved_branch_o),
        .resolve_branch_o   (resolve_branch_o),
        .branch_exception_o (branch_exception)
    );

    csr_buffer csr_buffer_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .fu_data_i    (fu_data_i),
        .csr_valid_i  (csr_valid_i),
        .csr_commit_i (csr_commit_i),
        .csr_ready_o  (csr_ready),
        .csr_result_o (csr_result),
        .csr_addr_o   (csr_addr_o)
    );

    mult mult_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .mult_valid_i    (mult_valid_i),
        .fu_data_i       (mult_data),
        .result_o        (mult_result),
        .mult_valid_o    (mult_valid),
        .mult_trans_id_o (mult_trans_id)
    );

    // ------------------------------------------------------------
    // Write-back mux
    // ------------------------------------------------------------
    always_comb begin
        flu_o.valid     = alu_valid_i || branch_valid_i || csr_valid_i || mult_valid;
        flu_o.exception = branch_exception;
        // Branch link address when nothing else claims the port
        flu_o.result    = link_addr;
        flu_o.trans_id  = fu_data_i.trans_id;
        if (alu_valid_i) begin
            flu_o.result = alu_result;
        end else if (csr_valid_i) begin
            flu_o.result = csr_result;
        end else if (mult_valid) begin
            flu_o.result   = mult_result;
            flu_o.trans_id = mult_trans_id;
        end
    end

    // Only the CSR buffer can stall issue
    assign flu_ready_o = csr_ready;

    // At most one unit per cycle
    strobes_onehot: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $onehot0({alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i})
    ) else $error("ex_stage: more than one issue strobe");

    // Returning product owns the write-back port
    mult_port_free: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        mult_valid |-> !(alu_valid_i || branch_valid_i || csr_valid_i)
    ) else $error("ex_stage: write-back collision with multiplier result");

endmodule

`default_nettype wire

// File: tb/tb_ex_stage.sv
/*
 * Testbench for the execute stage
 * Directed stimulus table, LCG sweep of ALU and multiplier
 * operations against a reference model, cycle timeout
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage import ex_pkg::*; ();

    localparam int         SWEEP_OPS    = 200;
    localparam int         SWEEP_CYCLES = 2 * SWEEP_OPS;
    localparam logic [2:0] U_IDLE = 3'd0;
    localparam logic [2:0] U_ALU  = 3'd1;
    localparam logic [2:0] U_BR   = 3'd2;
    localparam logic [2:0] U_CSR  = 3'd3;
    localparam logic [2:0] U_MUL  = 3'd4;

    // One table row: stimulus, then expected values
    typedef struct packed {
        logic [2:0]  unit;
        fu_op_e      op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] pc;
        logic        pred_taken;
        logic [31:0] pred_addr;
        logic [2:0]  tid;
        logic        commit;
        logic        flush;
        logic        exp_valid;
        logic [31:0] exp_result;
        logic [2:0]  exp_tid;
        logic        exp_taken;
        logic        exp_mispredict;
        logic [31:0] exp_target;
        logic        exp_exc;
        logic        exp_ready;
        logic        chk_addr;
        logic [11:0] exp_addr;
    } row_t;

    logic           clk_i = 1'b0;
    logic           rst_ni;
    logic           flush;
    fu_data_t       fu_data;
    logic [31:0]    pc;
    logic           alu_valid;
    logic           branch_valid;
    logic           csr_valid;
    logic           mult_valid;
    branchpredict_t predict;
    logic           commit;
    flu_out_t       flu;
    logic           ready;
    bp_resolve_t    resolved;
    logic           resolve;
    logic [11:0]    csr_addr;

    row_t        table_q[$];
    logic [31:0] lcg_state   = 32'd35298;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    always #10 clk_i = ~clk_i;

    ex_stage ex_stage_inst (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .flush_i           (flush),
        .fu_data_i         (fu_data),
        .pc_i              (pc),
        .alu_valid_i       (alu_valid),
        .branch_valid_i    (branch_valid),
        .csr_valid_i       (csr_valid),
        .mult_valid_i      (mult_valid),
        .branch_predict_i  (predict),
        .csr_commit_i      (commit),
        .flu_o             (flu),
        .flu_ready_o       (ready),
        .resolved_branch_o (resolved),
        .resolve_branch_o  (resolve),
        .csr_addr_o        (csr_addr)
    );

    // ------------------------------------------------------------
    // Reference model and random source
    // ------------------------------------------------------------
    function automatic logic [31:0] ref_result(input fu_op_e op, input logic [31:0] a,
                                               input logic [31:0] b);
        logic [63:0] wide;
        logic [4:0]  sh;
        sh         = b[4:0];
        ref_result = 32'd0;
        case (op)
            ADD:  ref_result = a + b;
            SUB:  ref_result = a + ~b + 32'd1;
            SLL:  ref_result = a << sh;
            SRL:  ref_result = a >> sh;
            SRA: begin
                wide       = {{32{a[31]}}, a} >> sh;
                ref_result = wide[31:0];
            end
            // Signed compare by flipping the sign bits
            SLTS: ref_result = {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            SLTU: ref_result = {31'd0, a < b};
            XORL: ref_result = a ^ b;
            ORL:  ref_result = a | b;
            ANDL: ref_result = a & b;
            MUL: begin
                wide       = {32'd0, a} * {32'd0, b};
                ref_result = wide[31:0];
            end
            MULH: begin
                wide       = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                ref_result = wide[63:32];
            end
            MULHU: begin
                wide       = {32'd0, a} * {32'd0, b};
                ref_result = wide[63:32];
            end
            default: ref_result = 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ------------------------------------------------------------
    // Error handling and checks
    // ------------------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at time %0t: %s got %h expected %h", $time, what, got, exp);
            abort_run("Stopping at the first failed check");
        end
    endtask

    task automatic check_row(input row_t r);
        check_val("write-back valid", 32'(flu.valid), 32'(r.exp_valid));
        if (r.exp_valid) begin
            check_val("write-back result", flu.result, r.exp_result);
            check_val("write-back trans_id", 32'(flu.trans_id), 32'(r.exp_tid));
        end
        check_val("issue ready", 32'(ready), 32'(r.exp_ready));
        check_val("resolve strobe", 32'(resolve), 32'(r.unit == U_BR));
        check_val("resolution valid", 32'(resolved.valid), 32'(r.unit == U_BR));
        if (r.unit == U_BR) begin
            check_val("resolution pc", resolved.pc, r.pc);
            check_val("branch target", resolved.target_address, r.exp_target);
            check_val("branch taken", 32'(resolved.is_taken), 32'(r.exp_taken));
            check_val("mispredict", 32'(resolved.is_mispredict), 32'(r.exp_mispredict));
        end
        check_val("exception valid", 32'(flu.exception.valid), 32'(r.exp_exc));
        if (r.exp_exc) begin
            check_val("exception cause", flu.exception.cause, 32'd0);
            check_val("exception tval", flu.exception.tval, r.exp_target);
        end
        if (r.chk_addr) begin
            check_val("CSR address", 32'(csr_addr), 32'(r.exp_addr));
        end
    endtask

    // Drive just after the edge, check mid-cycle
    task automatic apply_row(input row_t r);
        @(posedge clk_i);
        #2;
        fu_data.operator        = r.op;
        fu_data.operand_a       = r.a;
        fu_data.operand_b       = r.b;
        fu_data.imm             = r.imm;
        fu_data.trans_id        = r.tid;
        pc                      = r.pc;
        predict.predict_taken   = r.pred_taken;
        predict.predict_address = r.pred_addr;
        alu_valid               = (r.unit == U_ALU);
        branch_valid            = (r.unit == U_BR);
        csr_valid               = (r.unit == U_CSR);
        mult_valid              = (r.unit == U_MUL);
        commit                  = r.commit;
        flush                   = r.flush;
        @(negedge clk_i);
        check_row(r);
    endtask

    // ------------------------------------------------------------
    // Table construction
    // ------------------------------------------------------------
    function automatic row_t blank_row();
        row_t r;
        r           = '0;
        r.unit      = U_IDLE;
        r.exp_ready = 1'b1;
        return r;
    endfunction

    task automatic push_alu(input fu_op_e op, input logic [31:0] a, input logic [31:0] b,
                            input logic [2:0] tid, input logic [31:0] exp);
        row_t r;
        r            = blank_row();
        r.unit       = U_ALU;
        r.op         = op;
        r.a          = a;
        r.b          = b;
        r.tid        = tid;
        r.exp_valid  = 1'b1;
        r.exp_result = exp;
        r.exp_tid    = tid;
        table_q.push_back(r);
    endtask

    task automatic push_branch(input fu_op_e op, input logic [31:0] a, input logic [31:0] b,
                               input logic [31:0] imm, input logic [31:0] pc_val,
                               input logic pt, input logic [31:0] pa, input logic [2:0] tid,
                               input logic taken, input logic misp,
                               input logic [31:0] target, input logic exc);
        row_t r;
        r                = blank_row();
        r.unit           = U_BR;
        r.op             = op;
        r.a              = a;
        r.b              = b;
        r.imm            = imm;
        r.pc             = pc_val;
        r.pred_taken     = pt;
        r.pred_addr      = pa;
        r.tid            = tid;
        r.exp_valid      = 1'b1;
        // Link address of a 4-byte instruction
        r.exp_result     = pc_val + 32'd4;
        r.exp_tid        = tid;
        r.exp_taken      = taken;
        r.exp_mispredict = misp;
        r.exp_target     = target;
        r.exp_exc        = exc;
        table_q.push_back(r);
    endtask

    task automatic push_csr(input logic [31:0] a, input logic [31:0] b, input logic [2:0] tid);
        row_t r;
        r            = blank_row();
        r.unit       = U_CSR;
        r.op         = CSR_RW;
        r.a          = a;
        r.b          = b;
        r.tid        = tid;
        r.exp_valid  = 1'b1;
        r.exp_result = a;
        r.exp_tid    = tid;
        table_q.push_back(r);
    endtask

    task automatic push_mult(input fu_op_e op, input logic [31:0] a, input logic [31:0] b,
                             input logic [2:0] tid, input logic ret_valid,
                             input logic [31:0] ret_result, input logic [2:0] ret_tid);
        row_t r;
        r            = blank_row();
        r.unit       = U_MUL;
        r.op         = op;
        r.a          = a;
        r.b          = b;
        r.tid        = tid;
        r.exp_valid  = ret_valid;
        r.exp_result = ret_result;
        r.exp_tid    = ret_tid;
        table_q.push_back(r);
    endtask

    task automatic push_idle(input logic cmt, input logic fl, input logic rdy,
                             input logic chk, input logic [11:0] addr, input logic ret_valid,
                             input logic [31:0] ret_result, input logic [2:0] ret_tid);
        row_t r;
        r            = blank_row();
        r.commit     = cmt;
        r.flush      = fl;
        r.exp_ready  = rdy;
        r.chk_addr   = chk;
        r.exp_addr   = addr;
        r.exp_valid  = ret_valid;
        r.exp_result = ret_result;
        r.exp_tid    = ret_tid;
        table_q.push_back(r);
    endtask

    task automatic build_table();
        push_alu(ADD,  32'd5,        32'd7,        3'd1, 32'd12);
        push_alu(SUB,  32'd5,        32'd7,        3'd2, 32'hFFFF_FFFE);
        push_alu(SLL,  32'd1,        32'h0000_003F, 3'd3, 32'h8000_0000);
        push_alu(SRL,  32'h8000_0000, 32'd4,       3'd4, 32'h0800_0000);
        push_alu(SRA,  32'h8000_0000, 32'd4,       3'd5, 32'hF800_0000);
        push_alu(SLTS, 32'hFFFF_FFFF, 32'd1,       3'd6, 32'd1);
        push_alu(SLTU, 32'hFFFF_FFFF, 32'd1,       3'd7, 32'd0);
        push_alu(XORL, 32'hF0F0_F0F0, 32'hFF00_FF00, 3'd0, 32'h0FF0_0FF0);
        push_alu(ORL,  32'hF0F0_F0F0, 32'h0F0F_0000, 3'd1, 32'hFFFF_F0F0);
        push_alu(ANDL, 32'hF0F0_F0F0, 32'hFF00_FF00, 3'd2, 32'hF000_F000);

        // op, a, b, imm, pc, prediction, tid, taken, mispredict, target, exception
        push_branch(EQ, 32'd5, 32'd5, 32'h40, 32'h1000, 1'b1, 32'h1040, 3'd3,
                    1'b1, 1'b0, 32'h1040, 1'b0);
        // Not taken with bit 1 set in the target, so no exception
        push_branch(NE, 32'd1, 32'd1, 32'h6, 32'h1000, 1'b0, 32'h0, 3'd4,
                    1'b0, 1'b0, 32'h1006, 1'b0);
        push_branch(LTS, 32'hFFFF_FFFD, 32'd2, 32'h20, 32'h2000, 1'b0, 32'h0, 3'd5,
                    1'b1, 1'b1, 32'h2020, 1'b0);
        push_branch(GEU, 32'd1, 32'd2, 32'h8, 32'h3000, 1'b1, 32'h3008, 3'd6,
                    1'b0, 1'b1, 32'h3008, 1'b0);
        // Right direction, wrong address
        push_branch(LTU, 32'd1, 32'd2, 32'h8, 32'h3000, 1'b1, 32'h3010, 3'd7,
                    1'b1, 1'b1, 32'h3008, 1'b0);
        push_branch(GES, 32'd2, 32'd2, 32'h12, 32'h4000, 1'b1, 32'h4012, 3'd0,
                    1'b1, 1'b0, 32'h4012, 1'b1);
        push_branch(JALR, 32'h5001, 32'd0, 32'h10, 32'h6000, 1'b1, 32'h5010, 3'd1,
                    1'b1, 1'b0, 32'h5010, 1'b0);
        push_branch(JALR, 32'h7000, 32'd0, 32'h3, 32'h6000, 1'b1, 32'h7002, 3'd2,
                    1'b1, 1'b0, 32'h7002, 1'b1);

        // CSR released by commit, then by flush
        push_csr(32'hCAFE_0001, 32'h0000_0305, 3'd3);
        push_idle(1'b0, 1'b0, 1'b0, 1'b1, 12'h305, 1'b0, 32'd0, 3'd0);
        push_idle(1'b1, 1'b0, 1'b0, 1'b1, 12'h305, 1'b0, 32'd0, 3'd0);
        push_idle(1'b0, 1'b0, 1'b1, 1'b1, 12'h305, 1'b0, 32'd0, 3'd0);
        push_csr(32'h1234_5678, 32'hFFFF_F342, 3'd4);
        push_idle(1'b0, 1'b0, 1'b0, 1'b1, 12'h342, 1'b0, 32'd0, 3'd0);
        push_idle(1'b0, 1'b1, 1'b0, 1'b0, 12'h0,   1'b0, 32'd0, 3'd0);
        push_idle(1'b0, 1'b0, 1'b1, 1'b0, 12'h0,   1'b0, 32'd0, 3'd0);

        // Back-to-back multiplies, each returning one cycle later
        push_mult(MUL,   32'd7,        32'd6, 3'd5, 1'b0, 32'd0,        3'd0);
        push_mult(MULH,  32'hFFFF_FFFF, 32'd2, 3'd6, 1'b1, 32'd42,       3'd5);
        push_mult(MULHU, 32'hFFFF_FFFF, 32'd2, 3'd7, 1'b1, 32'hFFFF_FFFF, 3'd6);
        push_mult(MULH, 32'h8000_0000, 32'h8000_0000, 3'd0, 1'b1, 32'd1, 3'd7);
        push_idle(1'b0, 1'b0, 1'b1, 1'b0, 12'h0, 1'b1, 32'h4000_0000, 3'd0);
        push_idle(1'b0, 1'b0, 1'b1, 1'b0, 12'h0, 1'b0, 32'd0, 3'd0);

        // Flush kills the returning product
        push_mult(MUL, 32'd3, 32'd3, 3'd1, 1'b0, 32'd0, 3'd0);
        push_idle(1'b0, 1'b1, 1'b1, 1'b0, 12'h0, 1'b0, 32'd0, 3'd0);
        push_idle(1'b0, 1'b0, 1'b1, 1'b0, 12'h0, 1'b0, 32'd0, 3'd0);
    endtask

    // ------------------------------------------------------------
    // Random sweep, one issue cycle and one drain cycle per op
    // ------------------------------------------------------------
    task automatic run_sweep();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pick;
        logic [4:0]  idx;
        fu_op_e      op;
        row_t        issue;
        row_t        drain;
        for (int n = 0; n < SWEEP_OPS; n++) begin
            a    = next_rand();
            b    = next_rand();
            pick = next_rand();
            idx = 5'(pick[31:16] % 16'd13);
            // ALU operators sit at 0 to 9, the multiplier ones from 18
            op = (idx < 5'd10) ? fu_op_e'(idx) : fu_op_e'(idx + 5'd8);
            issue     = blank_row();
            drain     = blank_row();
            issue.op  = op;
            issue.a   = a;
            issue.b   = b;
            issue.tid = pick[2:0];
            if (op inside {MUL, MULH, MULHU}) begin
                issue.unit       = U_MUL;
                drain.exp_valid  = 1'b1;
                drain.exp_result = ref_result(op, a, b);
                drain.exp_tid    = pick[2:0];
            end else begin
                issue.unit       = U_ALU;
                issue.exp_valid  = 1'b1;
                issue.exp_result = ref_result(op, a, b);
                issue.exp_tid    = pick[2:0];
            end
            apply_row(issue);
            apply_row(drain);
        end
    endtask

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            abort_run($sformatf("Timeout: run did not finish within %0d cycles", cycle_limit));
        end
    end

    initial begin
        rst_ni       = 1'b0;
        flush        = 1'b0;
        fu_data      = '0;
        pc           = 32'd0;
        alu_valid    = 1'b0;
        branch_valid = 1'b0;
        csr_valid    = 1'b0;
        mult_valid   = 1'b0;
        predict      = '0;
        commit       = 1'b0;
        build_table();
        cycle_limit = 2 * table_q.size() + SWEEP_CYCLES + 50;

        repeat (10) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        @(negedge clk_i);
        check_val("valid after reset", 32'(flu.valid), 32'd0);
        check_val("resolve after reset", 32'(resolve), 32'd0);
        check_val("resolution after reset", 32'(resolved.valid), 32'd0);
        check_val("ready after reset", 32'(ready), 32'd1);

        foreach (table_q[i]) begin
            apply_row(table_q[i]);
        end
        run_sweep();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hw/ex_pkg.sv
hw/alu.sv
hw/branch_unit.sv
hw/csr_buffer.sv
hw/mult.sv
hw/ex_stage.sv
tb/tb_ex_stage.sv

// File: run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -f compile.f \
    --top-module tb_ex_stage -o sim_ex_stage
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed"
    exit "$status"
fi

./obj_dir/sim_ex_stage
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed"
    exit "$status"
fi

exit 0
